//--- design/float_add.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Adder and subtractor that aligns two operands and leaves an
// unnormalized sign, exponent and mantissa for the packer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module float_add (
    input  logic                                 a_sign,
    input  logic                                 b_sign,
    input  logic                                 subtract,
    input  logic [float_fmt_pkg::wexp_width-1:0] a_exp,
    input  logic [float_fmt_pkg::wexp_width-1:0] b_exp,
    input  logic [float_fmt_pkg::wman_width-1:0] a_man,
    input  logic [float_fmt_pkg::wman_width-1:0] b_man,
    output logic                                 sign,
    output logic [float_fmt_pkg::wexp_width-1:0] exp,
    output logic [float_fmt_pkg::wman_width-1:0] man
);
    import float_fmt_pkg::*;

    logic                  b_sign_eff;
    logic                  a_larger;
    logic                  big_sign;
    logic                  small_sign;
    logic [wexp_width-1:0] big_exp;
    logic [wexp_width-1:0] small_exp;
    logic [wexp_width-1:0] exp_diff;
    logic [wman_width-1:0] big_man;
    logic [wman_width-1:0] small_man;
    logic [wman_width-1:0] small_aligned;
    logic [wman_width-1:0] man_raw;

    // Subtraction is an addition with the second sign inverted
    assign b_sign_eff = b_sign ^ subtract;

    // Order by exponent first and by mantissa on a tie, so the larger
    // magnitude is always the minuend
    assign a_larger = (a_exp > b_exp) || ((a_exp == b_exp) && (a_man >= b_man));

    assign big_sign   = a_larger ? a_sign     : b_sign_eff;
    assign small_sign = a_larger ? b_sign_eff : a_sign;
    assign big_exp    = a_larger ? a_exp      : b_exp;
    assign small_exp  = a_larger ? b_exp      : a_exp;
    assign big_man    = a_larger ? a_man      : b_man;
    assign small_man  = a_larger ? b_man      : a_man;

    // Alignment truncates, the bits pushed out on the right are gone
    assign exp_diff      = big_exp - small_exp;
    assign small_aligned = small_man >> exp_diff;

    // Like signs add magnitudes and may set the carry bit; unlike signs
    // subtract, which cannot go below zero given the ordering above
    assign man_raw = (big_sign == small_sign) ? big_man + small_aligned
                                              : big_man - small_aligned;

    // Bit 9 never carries information
    assign man = {1'b0, man_raw[wman_width-2:0]};
    assign exp = big_exp;

    // Exact cancellation gives +0, any other result keeps the sign of
    // the larger operand
    assign sign = ((big_sign != small_sign) && (man_raw == '0)) ? 1'b0 : big_sign;

endmodule

//--- design/float_combine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Normalizer and packer: turns an unnormalized sign, exponent
// and mantissa into bfloat16 with subnormal and overflow handling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module float_combine (
    input  logic                                  sign,
    input  logic [float_fmt_pkg::wexp_width-1:0]  exp,
    input  logic [float_fmt_pkg::wman_width-1:0]  man,
    output logic [float_fmt_pkg::float_width-1:0] result
);
    import float_fmt_pkg::*;

    // The counters look at carry, hidden bit and fraction
    localparam int lz_width = wman_width - 1;

    logic [wexp_width-1:0]        exp_offset;
    logic [wexp_width-1:0]        man_shift;
    logic signed [wexp_width-1:0] final_exp;
    logic [wexp_width-1:0]        sub_shift;
    logic [lz_width-1:0]          man_shifted_left;
    logic [man_width:0]           final_man;
    logic [man_width:0]           sub_man;

    // Exponent correction is 1 minus the leading zeros: a set carry
    // raises the exponent by one, a leading one at the hidden bit keeps it
    float_lzc #(
        .in_width (lz_width),
        .out_width(wexp_width),
        .out_step (-1),
        .out_bias (1)
    ) exp_offset_lzc (
        .in   (man[lz_width-1:0]),
        .count(exp_offset)
    );

    // Plain count, used as the left shift that puts the leading one on top
    float_lzc #(
        .in_width (lz_width),
        .out_width(wexp_width),
        .out_step (1),
        .out_bias (0)
    ) man_shift_lzc (
        .in   (man[lz_width-1:0]),
        .count(man_shift)
    );

    assign final_exp        = exp + exp_offset;
    assign man_shifted_left = man[lz_width-1:0] << man_shift;

    // Dropping the bottom bit moves the leading one to the hidden position
    assign final_man = man_shifted_left[lz_width-1:1];

    // Below the normal range the mantissa goes back right until the
    // exponent would read 1, which is the subnormal scale
    assign sub_shift = wexp_width'(1) - final_exp;
    assign sub_man   = final_man >> sub_shift;

    always_comb begin
        result[float_width-1] = sign;
        if (final_exp <= 0) begin
            // Subnormal or flushed to zero
            result[float_width-2:man_width] = '0;
            result[man_width-1:0]           = sub_man[man_width-1:0];
        end else if (final_exp >= exp_all_ones) begin
            // Past the largest finite value, saturate to infinity
            result[float_width-2:man_width] = exp_width'(exp_all_ones);
            result[man_width-1:0]           = '0;
        end else if (final_man[man_width]) begin
            result[float_width-2:man_width] = final_exp[exp_width-1:0];
            result[man_width-1:0]           = final_man[man_width-1:0];
        end else begin
            // Nothing left in the mantissa
            result[float_width-2:0] = '0;
        end
    end

endmodule

//--- design/float_fmt_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bfloat16 number format: field widths, bias and the widened
// exponent and mantissa widths used inside the datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package float_fmt_pkg;

    // Width of the biased exponent field
    localparam int exp_width = 8;

    // Width of the stored fraction, without the hidden bit
    localparam int man_width = 7;

    // Sign, exponent and fraction packed together
    localparam int float_width = exp_width + man_width + 1;

    // Exponent bias of the encoding
    localparam int exp_bias = 127;

    // Internal exponent width
    // The top bit is a sign that flags underflow, the next one catches
    // exponents that ran past the largest finite value
    localparam int wexp_width = exp_width + 2;

    // Internal mantissa width
    // Bit 9 is always zero, bit 8 holds an add or multiply carry and
    // bit 7 is the hidden bit, with the fraction below it
    localparam int wman_width = man_width + 3;

    // Exponent field value reserved for infinity and NaN
    localparam int exp_all_ones = (1 << exp_width) - 1;

endpackage

//--- design/float_lzc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Leading-zero counter with a scaled and offset result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module float_lzc #(
    parameter int in_width  = 8,
    parameter int out_width = 4,
    parameter int out_step  = 1,
    parameter int out_bias  = 0
) (
    input  logic [in_width-1:0]  in,
    output logic [out_width-1:0] count
);

    // Number of zeros above the first set bit
    int zeros;

    always_comb begin
        // An all-zero input counts every bit as a leading zero
        zeros = in_width;
        // Walk upwards so that the highest set bit decides last
        for (int i = 0; i < in_width; i++) begin
            if (in[i]) begin
                zeros = in_width - 1 - i;
            end
        end
    end

    // With a step of -1 and a bias of 1 the same count becomes an
    // exponent correction instead of a shift amount
    assign count = out_width'(out_bias + out_step * zeros);

endmodule

//--- design/float_mul.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiplier producing an unnormalized sign, exponent and
// mantissa from two unpacked operands
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module float_mul (
    input  logic                                 a_sign,
    input  logic                                 b_sign,
    input  logic [float_fmt_pkg::wexp_width-1:0] a_exp,
    input  logic [float_fmt_pkg::wexp_width-1:0] b_exp,
    input  logic [float_fmt_pkg::wman_width-1:0] a_man,
    input  logic [float_fmt_pkg::wman_width-1:0] b_man,
    output logic                                 sign,
    output logic [float_fmt_pkg::wexp_width-1:0] exp,
    output logic [float_fmt_pkg::wman_width-1:0] man
);
    import float_fmt_pkg::*;

    // Width of the hidden bit plus fraction
    localparam int sig_width = man_width + 1;

    logic [sig_width-1:0]   a_sig;
    logic [sig_width-1:0]   b_sig;
    logic [2*sig_width-1:0] product;

    assign sign = a_sign ^ b_sign;

    // Both exponents carry the bias, so one copy is taken back out
    // The result may be negative or past the finite range, the packer
    // deals with both
    assign exp = a_exp + b_exp - wexp_width'(exp_bias);

    // Only the hidden bit and fraction take part, carry and spare bits
    // of the inputs are always clear
    assign a_sig   = a_man[sig_width-1:0];
    assign b_sig   = b_man[sig_width-1:0];
    assign product = a_sig * b_sig;

    // A product of two values in [1,2) has its leading one at bit 14 or,
    // when it reached 2 or more, at bit 15
    // Keeping bits 15 down to 7 lands bit 14 on the hidden position and
    // bit 15 on the carry, everything lower is truncated
    assign man = {1'b0, product[2*sig_width-1:man_width]};

endmodule

//--- design/float_op_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operation codes and fixed results of the arithmetic unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package float_op_pkg;

    // Requested operation
    // The unused fourth code is treated like an addition
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2
    } float_op_t;

    // Quiet NaN returned for every invalid operation
    // Positive sign, all-ones exponent, top fraction bit set
    localparam logic [float_fmt_pkg::float_width-1:0] qnan_value = 16'h7FC0;

endpackage

//--- design/float_split.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand unpacker: fields, hidden bit and class flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module float_split (
    input  logic [float_fmt_pkg::float_width-1:0] value,
    output logic                                  sign,
    output logic [float_fmt_pkg::wexp_width-1:0]  exp,
    output logic [float_fmt_pkg::wman_width-1:0]  man,
    output logic                                  is_nan,
    output logic                                  is_inf,
    output logic                                  is_zero
);
    import float_fmt_pkg::*;

    logic [exp_width-1:0] exp_field;
    logic [man_width-1:0] frac_field;
    logic                 exp_zero;
    logic                 exp_max;
    logic                 frac_zero;

    assign sign       = value[float_width-1];
    assign exp_field  = value[float_width-2:man_width];
    assign frac_field = value[man_width-1:0];

    assign exp_zero  = (exp_field == '0);
    assign exp_max   = (exp_field == exp_width'(exp_all_ones));
    assign frac_zero = (frac_field == '0);

    // Subnormals share the scale of the smallest normal exponent, so a
    // zero field is read as an effective exponent of 1
    assign exp = exp_zero ? wexp_width'(1) : wexp_width'(exp_field);

    // Carry and spare bits start clear, the hidden bit is only dropped
    // for subnormals and zero
    assign man = {2'b00, ~exp_zero, frac_field};

    // Class flags
    // A maximum exponent is infinity when the fraction is empty,
    // anything else there is a NaN
    assign is_inf  = exp_max & frac_zero;
    assign is_nan  = exp_max & ~frac_zero;
    assign is_zero = exp_zero & frac_zero;

endmodule

//--- design/float_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bfloat16 add, subtract and multiply unit with a two-stage
// pipeline and special-value handling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module float_unit (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_valid,
    input  float_op_pkg::float_op_t               op,
    input  logic [float_fmt_pkg::float_width-1:0] a,
    input  logic [float_fmt_pkg::float_width-1:0] b,
    output logic                                  out_valid,
    output logic [float_fmt_pkg::float_width-1:0] result
);
    import float_fmt_pkg::*;
    import float_op_pkg::*;

    logic a_sign, a_nan, a_inf, a_zero, b_sign, b_nan, b_inf, b_zero;
    logic [wexp_width-1:0] a_exp, b_exp;
    logic [wman_width-1:0] a_man, b_man;

    // Stage 1 registers
    logic                  s1_valid;
    float_op_t             s1_op;
    logic                  s1_a_sign, s1_a_nan, s1_a_inf, s1_a_zero;
    logic                  s1_b_sign, s1_b_nan, s1_b_inf, s1_b_zero;
    logic [wexp_width-1:0] s1_a_exp, s1_b_exp;
    logic [wman_width-1:0] s1_a_man, s1_b_man;

    // Stage 2 datapath
    logic                   is_mul, is_sub, b_sign_eff;
    logic                   add_sign, mul_sign, sel_sign;
    logic [wexp_width-1:0]  add_exp, mul_exp, sel_exp;
    logic [wman_width-1:0]  add_man, mul_man, sel_man;
    logic [float_width-1:0] packed_result;
    logic                   special;
    logic [float_width-1:0] special_value;

    float_split split_a (.value(a), .sign(a_sign), .exp(a_exp), .man(a_man),
        .is_nan(a_nan), .is_inf(a_inf), .is_zero(a_zero));
    float_split split_b (.value(b), .sign(b_sign), .exp(b_exp), .man(b_man),
        .is_nan(b_nan), .is_inf(b_inf), .is_zero(b_zero));

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
        // The operand payload is captured with each request
        if (in_valid) begin
            s1_op     <= op;
            {s1_a_sign, s1_a_exp, s1_a_man} <= {a_sign, a_exp, a_man};
            {s1_b_sign, s1_b_exp, s1_b_man} <= {b_sign, b_exp, b_man};
            {s1_a_nan, s1_a_inf, s1_a_zero} <= {a_nan, a_inf, a_zero};
            {s1_b_nan, s1_b_inf, s1_b_zero} <= {b_nan, b_inf, b_zero};
        end
    end

    // The spare fourth code falls into the add path with is_sub low
    assign is_mul = (s1_op == op_mul);
    assign is_sub = (s1_op == op_sub);

    float_add add_path (.a_sign(s1_a_sign), .b_sign(s1_b_sign), .subtract(is_sub),
        .a_exp(s1_a_exp), .b_exp(s1_b_exp), .a_man(s1_a_man), .b_man(s1_b_man),
        .sign(add_sign), .exp(add_exp), .man(add_man));
    float_mul mul_path (.a_sign(s1_a_sign), .b_sign(s1_b_sign),
        .a_exp(s1_a_exp), .b_exp(s1_b_exp), .a_man(s1_a_man), .b_man(s1_b_man),
        .sign(mul_sign), .exp(mul_exp), .man(mul_man));

    assign sel_sign = is_mul ? mul_sign : add_sign;
    assign sel_exp  = is_mul ? mul_exp  : add_exp;
    assign sel_man  = is_mul ? mul_man  : add_man;

    float_combine packer (.sign(sel_sign), .exp(sel_exp), .man(sel_man),
        .result(packed_result));

    assign b_sign_eff = s1_b_sign ^ is_sub;

    // Special operands bypass the datapath; NaN and the invalid
    // combinations win over a plain infinity
    always_comb begin
        special       = 1'b1;
        special_value = qnan_value;
        if (s1_a_nan || s1_b_nan) begin
            special_value = qnan_value;
        end else if (is_mul) begin
            if ((s1_a_inf && s1_b_zero) || (s1_b_inf && s1_a_zero)) begin
                special_value = qnan_value;
            end else if (s1_a_inf || s1_b_inf) begin
                special_value = {mul_sign, exp_width'(exp_all_ones), man_width'(0)};
            end else begin
                special = 1'b0;
            end
        end else if (s1_a_inf && s1_b_inf && (s1_a_sign != b_sign_eff)) begin
            special_value = qnan_value;
        end else if (s1_a_inf) begin
            special_value = {s1_a_sign, exp_width'(exp_all_ones), man_width'(0)};
        end else if (s1_b_inf) begin
            special_value = {b_sign_eff, exp_width'(exp_all_ones), man_width'(0)};
        end else begin
            special = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
        if (s1_valid) begin
            result <= special ? special_value : packed_result;
        end
    end

endmodule

//--- tb.f
+incdir+test
design/float_fmt_pkg.sv
design/float_op_pkg.sv
design/float_lzc.sv
design/float_split.sv
design/float_add.sv
design/float_mul.sv
design/float_combine.sv
design/float_unit.sv
test/float_unit_tb.sv

//--- test/float_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the bfloat16 unit: truncating add, multiply
// and the special-value rules, used for expected results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef float_model_svh
`define float_model_svh

// A zero exponent field reads as exponent 1 with no hidden bit
function automatic void model_unpack(input logic [float_width-1:0] v, output logic s,
    output int e, output int m);
    logic [exp_width-1:0] field;
    field = v[float_width-2:man_width];
    s = v[float_width-1];
    e = (field == '0) ? 1 : int'(field);
    m = int'(v[man_width-1:0]) + ((field == '0) ? 0 : (1 << man_width));
endfunction

// Mantissa arrives with its hidden bit at weight 1 << man_width
function automatic logic [float_width-1:0] model_pack(input logic s, input int e,
    input int m);
    int exp_v;
    int man_v;
    exp_v = e;
    man_v = m;
    if (man_v == 0) return {s, exp_width'(0), man_width'(0)};
    // A carry above the hidden bit costs the lowest fraction bit
    while (man_v >= (2 << man_width)) begin
        man_v = man_v >> 1;
        exp_v = exp_v + 1;
    end
    while (man_v < (1 << man_width)) begin
        man_v = man_v << 1;
        exp_v = exp_v - 1;
    end
    if (exp_v <= 0) begin
        // Back down to the scale of exponent 1, dropping whatever falls off
        man_v = (1 - exp_v >= 16) ? 0 : (man_v >> (1 - exp_v));
        return {s, exp_width'(0), man_width'(man_v)};
    end
    if (exp_v >= exp_all_ones) return {s, exp_width'(exp_all_ones), man_width'(0)};
    return {s, exp_width'(exp_v), man_width'(man_v)};
endfunction

function automatic logic [float_width-1:0] model_add(input logic [float_width-1:0] x, y,
    input logic sub);
    logic xs, ys, bs, ss;
    int xe, ye, xm, ym, be, se, bm, sm, sum;
    model_unpack(x, xs, xe, xm);
    model_unpack(y, ys, ye, ym);
    ys = ys ^ sub;
    // The operand with the larger magnitude sets exponent and sign
    if ((xe > ye) || ((xe == ye) && (xm >= ym))) begin
        {bs, be, bm, ss, se, sm} = {xs, xe, xm, ys, ye, ym};
    end else begin
        {bs, be, bm, ss, se, sm} = {ys, ye, ym, xs, xe, xm};
    end
    sm = (be - se >= 16) ? 0 : (sm >> (be - se));
    sum = (bs == ss) ? bm + sm : bm - sm;
    // Exact cancellation comes out as positive zero
    return model_pack(((bs != ss) && (sum == 0)) ? 1'b0 : bs, be, sum);
endfunction

function automatic logic [float_width-1:0] model_mul(input logic [float_width-1:0] x, y);
    logic xs, ys;
    int xe, ye, xm, ym;
    model_unpack(x, xs, xe, xm);
    model_unpack(y, ys, ye, ym);
    return model_pack(xs ^ ys, xe + ye - exp_bias, (xm * ym) >> man_width);
endfunction

// Returns 1 with the forced result when NaN or infinity decides the answer
function automatic bit model_special(input float_op_t f_op, input logic [float_width-1:0] x,
    y, output logic [float_width-1:0] value);
    logic x_nan, y_nan, x_inf, y_inf, x_zero, y_zero, y_sign;
    x_inf  = (x[float_width-2:man_width] == '1) && (x[man_width-1:0] == '0);
    y_inf  = (y[float_width-2:man_width] == '1) && (y[man_width-1:0] == '0);
    x_nan  = (x[float_width-2:man_width] == '1) && !x_inf;
    y_nan  = (y[float_width-2:man_width] == '1) && !y_inf;
    x_zero = (x[float_width-2:0] == '0);
    y_zero = (y[float_width-2:0] == '0);
    y_sign = y[float_width-1] ^ (f_op == op_sub);
    value  = qnan_value;
    if (x_nan || y_nan) return 1'b1;
    if (f_op == op_mul) begin
        if ((x_inf && y_zero) || (y_inf && x_zero)) return 1'b1;
        value = {x[float_width-1] ^ y[float_width-1], exp_width'(exp_all_ones), man_width'(0)};
        return x_inf || y_inf;
    end
    // Infinities pointing opposite ways after the subtract flip are invalid
    if (x_inf && y_inf && (x[float_width-1] != y_sign)) return 1'b1;
    value = {x_inf ? x[float_width-1] : y_sign, exp_width'(exp_all_ones), man_width'(0)};
    return x_inf || y_inf;
endfunction

// The spare fourth code computes like an addition
function automatic logic [float_width-1:0] model_expected(input float_op_t f_op,
    input logic [float_width-1:0] x, y);
    logic [float_width-1:0] forced;
    if (model_special(f_op, x, y, forced)) return forced;
    if (f_op == op_mul) return model_mul(x, y);
    return model_add(x, y, f_op == op_sub);
endfunction

`endif

//--- test/float_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the bfloat16 unit: directed vectors, special
// values and a random back-to-back burst against the model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module float_unit_tb;
    import float_fmt_pkg::*;
    import float_op_pkg::*;

    `include "float_model.svh"

    // Cycles to wait for out_valid before giving up
    localparam int wait_limit = 20;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    float_op_t              op;
    logic [float_width-1:0] a;
    logic [float_width-1:0] b;
    logic                   out_valid;
    logic [float_width-1:0] result;

    int result_errors = 0;
    int latency_errors = 0;
    int seed = 22202;

    float_unit DUT (.clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .a(a), .b(b),
        .out_valid(out_valid), .result(result));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_result(input string name, input logic [float_width-1:0] got,
        input logic [float_width-1:0] expected);
        if (got !== expected) begin
            result_errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic compare_latency(input string name, input int got, input int expected);
        if (got != expected) begin
            latency_errors++;
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got,
                expected);
        end
    endtask

    // Inputs change and outputs are read 2 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Polls out_valid once per cycle
    // The count goes on from the cycles already spent since the request went out
    task automatic wait_result(input int elapsed, output int cycles);
        cycles = elapsed;
        while (!out_valid && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        if (!out_valid) begin
            $display("Timeout: out_valid stayed low for %0d cycles at %0t ns", wait_limit, $time);
            $display("sim failed");
            $finish;
        end
    endtask

    // One request on its own, then its value and its distance in cycles
    task automatic check_single(input float_op_t req_op, input logic [float_width-1:0] x, y);
        int cycles;
        in_valid = 1'b1;
        op = req_op;
        a = x;
        b = y;
        next_cycle();
        in_valid = 1'b0;
        // The cycle that carried the request is the first one of the delay
        wait_result(1, cycles);
        compare_latency($sformatf("out_valid delay for %h op%0d %h", x, req_op, y), cycles, 2);
        compare_result($sformatf("result for %h op%0d %h", x, req_op, y), result,
            model_expected(req_op, x, y));
    endtask

    task automatic idle_and_latency();
        int pulses;
        pulses = 0;
        repeat (4) begin
            next_cycle();
            if (out_valid !== 1'b0) begin
                pulses++;
            end
        end
        compare_latency("out_valid pulses while idle", pulses, 0);
        check_single(op_add, 16'h3F80, 16'h3F80);
        check_single(op_mul, 16'h4040, 16'hC000);
    endtask

    task automatic add_sub_vectors();
        check_single(op_add, 16'h4040, 16'h3F00);
        check_single(op_sub, 16'h3FC0, 16'h3F00);
        check_single(op_sub, 16'h4120, 16'h4120);
        check_single(op_add, 16'hC0A0, 16'h40A0);
        // The small addend falls entirely below the last fraction bit
        check_single(op_add, 16'h3F80, 16'h3A80);
        check_single(op_sub, 16'h3F80, 16'h3F81);
        check_single(float_op_t'(2'd3), 16'h4000, 16'hBF80);
    endtask

    task automatic mul_vectors();
        check_single(op_mul, 16'h4000, 16'h4040);
        check_single(op_mul, 16'h3FC0, 16'h3FC0);
        check_single(op_mul, 16'h3FFF, 16'h3FFF);
        check_single(op_mul, 16'hC2C8, 16'h3DCC);
        check_single(op_mul, 16'h7F00, 16'h4000);
        check_single(op_mul, 16'h7F7F, 16'hFF7F);
    endtask

    task automatic subnormal_vectors();
        check_single(op_add, 16'h0001, 16'h0001);
        check_single(op_sub, 16'h0080, 16'h0001);
        check_single(op_add, 16'h807F, 16'h0001);
        check_single(op_mul, 16'h0080, 16'h3F00);
        check_single(op_mul, 16'h0040, 16'h4000);
        check_single(op_mul, 16'h0C00, 16'h3300);
        check_single(op_mul, 16'h0100, 16'h0100);
    endtask

    task automatic special_value_vectors();
        check_single(op_add, 16'h7FC1, 16'h3F80);
        check_single(op_mul, 16'hFFFF, 16'h0000);
        check_single(op_sub, 16'h7F80, 16'h7F80);
        check_single(op_add, 16'h7F80, 16'hFF80);
        check_single(op_mul, 16'h7F80, 16'h0000);
        check_single(op_mul, 16'h8000, 16'hFF80);
        check_single(op_add, 16'hFF80, 16'h3F80);
        check_single(op_sub, 16'h3F80, 16'h7F80);
        check_single(op_mul, 16'hFF80, 16'hBF80);
        check_single(op_add, 16'h7F80, 16'h7F80);
    endtask

    // Twenty requests on consecutive cycles, collected by a second thread
    task automatic random_burst();
        logic [float_width-1:0] expected_q[$];
        int cycles;
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    in_valid = 1'b1;
                    op = float_op_t'(2'($random(seed)));
                    a = float_width'($random(seed));
                    b = float_width'($random(seed));
                    expected_q.push_back(model_expected(op, a, b));
                    next_cycle();
                end
                in_valid = 1'b0;
            end
            begin
                // The cycle that carries the first request is the first one counted
                next_cycle();
                wait_result(1, cycles);
                compare_latency("out_valid delay of first burst result", cycles, 2);
                for (int i = 0; i < 20; i++) begin
                    if (!out_valid) begin
                        result_errors++;
                        $display("Burst result %0d did not arrive at %0t ns", i, $time);
                    end
                    compare_result($sformatf("result of burst request %0d", i), result,
                        expected_q.pop_front());
                    next_cycle();
                end
            end
        join
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        op = op_add;
        a = '0;
        b = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        idle_and_latency();
        add_sub_vectors();
        mul_vectors();
        subnormal_vectors();
        special_value_vectors();
        random_burst();
        $display("result errors: %0d, latency errors: %0d", result_errors, latency_errors);
        if (result_errors + latency_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
